//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP      = tb_angle_control
FILELIST = verilog.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation failed"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/angle_control_top.sv
/*
 * top level, buttons to counters, display and host registers
 */

`timescale 1ns/10ps

module angle_control_top (
   input  logic                                i_CLK,
   input  logic                                i_RST,
   // push buttons, active low
   input  logic                                i_btn_theta_up,
   input  logic                                i_btn_theta_dn,
   input  logic                                i_btn_phi_up,
   input  logic                                i_btn_phi_dn,
   output logic [7:0]                          o_seg0,
   output logic [7:0]                          o_seg1,
   // host port
   input  logic                                i_awvalid,
   output logic                                o_awready,
   input  logic [angle_pkg::AXIL_ADDR_W-1:0]   i_awaddr,
   input  logic                                i_wvalid,
   output logic                                o_wready,
   input  logic [angle_pkg::AXIL_DATA_W-1:0]   i_wdata,
   input  logic [angle_pkg::AXIL_DATA_W/8-1:0] i_wstrb,
   output logic                                o_bvalid,
   input  logic                                i_bready,
   output logic [1:0]                          o_bresp,
   input  logic                                i_arvalid,
   output logic                                o_arready,
   input  logic [angle_pkg::AXIL_ADDR_W-1:0]   i_araddr,
   output logic                                o_rvalid,
   input  logic                                i_rready,
   output logic [angle_pkg::AXIL_DATA_W-1:0]   o_rdata,
   output logic [1:0]                          o_rresp
);

   logic                 theta_up;
   logic                 theta_dn;
   logic                 phi_up;
   logic                 phi_dn;
   angle_pkg::angle_t    theta;
   angle_pkg::angle_t    phi;
   angle_pkg::disp_sel_t disp_sel;

   // ------------------------------------------------------------------------
   // button presses
   // ------------------------------------------------------------------------
   button_edge u_btn_theta_up (.i_CLK(i_CLK), .i_RST(i_RST), .i_btn(i_btn_theta_up),
                               .o_press(theta_up));
   button_edge u_btn_theta_dn (.i_CLK(i_CLK), .i_RST(i_RST), .i_btn(i_btn_theta_dn),
                               .o_press(theta_dn));
   button_edge u_btn_phi_up   (.i_CLK(i_CLK), .i_RST(i_RST), .i_btn(i_btn_phi_up),
                               .o_press(phi_up));
   button_edge u_btn_phi_dn   (.i_CLK(i_CLK), .i_RST(i_RST), .i_btn(i_btn_phi_dn),
                               .o_press(phi_dn));

   // ------------------------------------------------------------------------
   // angle counters
   // ------------------------------------------------------------------------
   value_control #(
      .MIN_VAL  (angle_pkg::THETA_MIN),
      .MAX_VAL  (angle_pkg::THETA_MAX),
      .STEP     (angle_pkg::THETA_STEP),
      .INIT_VAL (angle_pkg::THETA_INIT)
   ) u_theta (
      .i_CLK (i_CLK), .i_RST (i_RST), .i_up (theta_up), .i_down (theta_dn),
      .o_value (theta)
   );

   value_control #(
      .MIN_VAL  (angle_pkg::PHI_MIN),
      .MAX_VAL  (angle_pkg::PHI_MAX),
      .STEP     (angle_pkg::PHI_STEP),
      .INIT_VAL (angle_pkg::PHI_INIT)
   ) u_phi (
      .i_CLK (i_CLK), .i_RST (i_RST), .i_up (phi_up), .i_down (phi_dn),
      .o_value (phi)
   );

   seg_display u_display (
      .i_CLK (i_CLK), .i_RST (i_RST), .i_theta (theta), .i_phi (phi),
      .i_sel (disp_sel), .o_seg0 (o_seg0), .o_seg1 (o_seg1)
   );

   angle_regs_axil u_regs (
      .i_CLK     (i_CLK),     .i_RST     (i_RST),
      .i_theta   (theta),     .i_phi     (phi),
      .i_awvalid (i_awvalid), .o_awready (o_awready), .i_awaddr (i_awaddr),
      .i_wvalid  (i_wvalid),  .o_wready  (o_wready),  .i_wdata  (i_wdata),
      .i_wstrb   (i_wstrb),   .o_bvalid  (o_bvalid),  .i_bready (i_bready),
      .o_bresp   (o_bresp),
      .i_arvalid (i_arvalid), .o_arready (o_arready), .i_araddr (i_araddr),
      .o_rvalid  (o_rvalid),  .i_rready  (i_rready),  .o_rdata  (o_rdata),
      .o_rresp   (o_rresp),
      .o_disp_sel (disp_sel)
   );

endmodule

//--- hdl/angle_pkg.sv
/*
 * shared widths, angle limits and steps, register map
 * display select enum and AXI response codes
 */

package angle_pkg;

   // ------------------------------------------------------------------------
   // angle widths and types
   // ------------------------------------------------------------------------
   localparam int ANGLE_W = 9;
   typedef logic [ANGLE_W-1:0] angle_t;
   typedef logic [15:0]        crad_t;

   // elevation range in degrees
   localparam angle_t THETA_MIN  = 9'd30;
   localparam angle_t THETA_MAX  = 9'd180;
   localparam angle_t THETA_STEP = 9'd5;
   localparam angle_t THETA_INIT = 9'd180;

   // azimuth range in degrees
   localparam angle_t PHI_MIN  = 9'd0;
   localparam angle_t PHI_MAX  = 9'd90;
   localparam angle_t PHI_STEP = 9'd2;
   localparam angle_t PHI_INIT = 9'd0;

   // deg to crad: deg * 1787 / 1024, about 100*pi/180
   localparam int unsigned CRAD_MUL   = 1787;
   localparam int unsigned CRAD_SHIFT = 10;

   // ------------------------------------------------------------------------
   // host register map
   // ------------------------------------------------------------------------
   localparam int AXIL_ADDR_W = 5;
   localparam int AXIL_DATA_W = 32;

   localparam logic [AXIL_ADDR_W-1:0] REG_THETA_DEG  = 5'h00;
   localparam logic [AXIL_ADDR_W-1:0] REG_PHI_DEG    = 5'h04;
   localparam logic [AXIL_ADDR_W-1:0] REG_THETA_CRAD = 5'h08;
   localparam logic [AXIL_ADDR_W-1:0] REG_PHI_CRAD   = 5'h0C;
   localparam logic [AXIL_ADDR_W-1:0] REG_CTRL       = 5'h10;

   typedef enum logic {
      DISP_THETA = 1'b0,
      DISP_PHI   = 1'b1
   } disp_sel_t;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- hdl/angle_regs_axil.sv
/*
 * AXI4-Lite slave with angle registers in degrees and centiradians
 * plus the display select control register
 */

`timescale 1ns/10ps

module angle_regs_axil (
   input  logic                                  i_CLK,
   input  logic                                  i_RST,
   input  angle_pkg::angle_t                     i_theta,
   input  angle_pkg::angle_t                     i_phi,
   // write address and data
   input  logic                                  i_awvalid,
   output logic                                  o_awready,
   input  logic [angle_pkg::AXIL_ADDR_W-1:0]     i_awaddr,
   input  logic                                  i_wvalid,
   output logic                                  o_wready,
   input  logic [angle_pkg::AXIL_DATA_W-1:0]     i_wdata,
   input  logic [angle_pkg::AXIL_DATA_W/8-1:0]   i_wstrb,
   output logic                                  o_bvalid,
   input  logic                                  i_bready,
   output logic [1:0]                            o_bresp,
   // read address and data
   input  logic                                  i_arvalid,
   output logic                                  o_arready,
   input  logic [angle_pkg::AXIL_ADDR_W-1:0]     i_araddr,
   output logic                                  o_rvalid,
   input  logic                                  i_rready,
   output logic [angle_pkg::AXIL_DATA_W-1:0]     o_rdata,
   output logic [1:0]                            o_rresp,
   output angle_pkg::disp_sel_t                  o_disp_sel
);

   logic [31:0]                          theta_prod;
   logic [31:0]                          phi_prod;
   angle_pkg::crad_t                     theta_crad;
   angle_pkg::crad_t                     phi_crad;
   logic                                 wr_accept;
   logic                                 wr_hs;
   logic                                 wr_ctrl;
   logic                                 rd_accept;
   logic                                 rd_hs;
   logic [angle_pkg::AXIL_DATA_W-1:0]    rd_data;
   logic                                 rd_err;

   // ------------------------------------------------------------------------
   // centiradian conversion, one cycle behind the counters
   // ------------------------------------------------------------------------
   assign theta_prod = i_theta * angle_pkg::CRAD_MUL;
   assign phi_prod   = i_phi * angle_pkg::CRAD_MUL;

   always_ff @(posedge i_CLK) begin
      theta_crad <= angle_pkg::crad_t'(theta_prod >> angle_pkg::CRAD_SHIFT);
      phi_crad   <= angle_pkg::crad_t'(phi_prod >> angle_pkg::CRAD_SHIFT);
   end

   // ------------------------------------------------------------------------
   // channel handshakes
   // ------------------------------------------------------------------------
   // address and data taken together, only with no response pending
   assign wr_accept = i_awvalid & i_wvalid & ~o_awready & ~o_bvalid;
   assign wr_hs     = o_awready & o_wready & i_awvalid & i_wvalid;
   assign wr_ctrl   = (i_awaddr == angle_pkg::REG_CTRL);
   assign rd_accept = i_arvalid & ~o_arready & ~o_rvalid;
   assign rd_hs     = o_arready & i_arvalid;

   // read decode, unmapped gives zero and SLVERR
   always_comb begin
      rd_data = '0;
      rd_err  = 1'b0;
      case (i_araddr)
         angle_pkg::REG_THETA_DEG:  rd_data[angle_pkg::ANGLE_W-1:0] = i_theta;
         angle_pkg::REG_PHI_DEG:    rd_data[angle_pkg::ANGLE_W-1:0] = i_phi;
         angle_pkg::REG_THETA_CRAD: rd_data[15:0] = theta_crad;
         angle_pkg::REG_PHI_CRAD:   rd_data[15:0] = phi_crad;
         angle_pkg::REG_CTRL:       rd_data[0] = o_disp_sel;
         default:                   rd_err = 1'b1;
      endcase
   end

   always_ff @(posedge i_CLK or negedge i_RST) begin
      if (!i_RST) begin
         o_awready  <= 1'b0;
         o_wready   <= 1'b0;
         o_bvalid   <= 1'b0;
         o_arready  <= 1'b0;
         o_rvalid   <= 1'b0;
         o_disp_sel <= angle_pkg::DISP_THETA;
      end else begin
         // ready pulses for one cycle
         o_awready <= wr_accept;
         o_wready  <= wr_accept;
         o_arready <= rd_accept;
         if (wr_hs) begin
            o_bvalid <= 1'b1;
            // only strobe 0 gates the select bit
            if (wr_ctrl && i_wstrb[0])
               o_disp_sel <= angle_pkg::disp_sel_t'(i_wdata[0]);
         end else if (i_bready) begin
            o_bvalid <= 1'b0;
         end
         if (rd_hs)
            o_rvalid <= 1'b1;
         else if (i_rready)
            o_rvalid <= 1'b0;
      end
   end

   // response payload, loaded at the handshake
   always_ff @(posedge i_CLK) begin
      if (wr_hs)
         o_bresp <= wr_ctrl ? angle_pkg::RESP_OKAY : angle_pkg::RESP_SLVERR;
      if (rd_hs) begin
         o_rdata <= rd_data;
         o_rresp <= rd_err ? angle_pkg::RESP_SLVERR : angle_pkg::RESP_OKAY;
      end
   end

   // responses hold, unchanged, until the master takes them
   a_rvalid_hold: assert property (
      @(posedge i_CLK) disable iff (!i_RST)
      o_rvalid && !i_rready |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp)
   );

   a_bvalid_hold: assert property (
      @(posedge i_CLK) disable iff (!i_RST)
      o_bvalid && !i_bready |=> o_bvalid && $stable(o_bresp)
   );

endmodule

//--- hdl/button_edge.sv
/*
 * press detector for one active-low push button
 */

`timescale 1ns/10ps

module button_edge (
   input  logic i_CLK,
   input  logic i_RST,
   input  logic i_btn,
   output logic o_press
);

   // two-flop synchronizer, idle level is high
   logic btn_meta;
   logic btn_sync;
   // synchronized level one cycle back
   logic btn_prev;

   always_ff @(posedge i_CLK or negedge i_RST) begin
      if (!i_RST) begin
         btn_meta <= 1'b1;
         btn_sync <= 1'b1;
         btn_prev <= 1'b1;
         o_press  <= 1'b0;
      end else begin
         btn_meta <= i_btn;
         btn_sync <= btn_meta;
         btn_prev <= btn_sync;
         // falling edge only, a held button gives one pulse
         o_press  <= btn_prev & ~btn_sync;
      end
   end

   // a press is a single-cycle pulse
   a_press_single: assert property (
      @(posedge i_CLK) disable iff (!i_RST)
      o_press |=> !o_press
   );

endmodule

//--- hdl/hex2seg.sv
/*
 * hex digit to seven-segment pattern, segments active low
 */

`timescale 1ns/10ps

module hex2seg (
   input  logic [3:0] i_num,
   output logic [6:0] o_seg
);

   // lit segments, bit 0 = a ... bit 6 = g
   logic [6:0] seg_on;

   always_comb begin
      case (i_num)
         4'h0: seg_on = 7'h3F;
         4'h1: seg_on = 7'h06;
         4'h2: seg_on = 7'h5B;
         4'h3: seg_on = 7'h4F;
         4'h4: seg_on = 7'h66;
         4'h5: seg_on = 7'h6D;
         4'h6: seg_on = 7'h7D;
         4'h7: seg_on = 7'h07;
         4'h8: seg_on = 7'h7F;
         4'h9: seg_on = 7'h6F;
         4'hA: seg_on = 7'h77;
         4'hB: seg_on = 7'h7C;
         4'hC: seg_on = 7'h39;
         4'hD: seg_on = 7'h5E;
         4'hE: seg_on = 7'h79;
         default: seg_on = 7'h71;
      endcase
   end

   // board drives segments low to light them
   assign o_seg = ~seg_on;

endmodule

//--- hdl/seg_display.sv
/*
 * two-digit hex display of the selected angle
 * decimal point of the low digit marks phi
 */

`timescale 1ns/10ps

module seg_display (
   input  logic                 i_CLK,
   input  logic                 i_RST,
   input  angle_pkg::angle_t    i_theta,
   input  angle_pkg::angle_t    i_phi,
   input  angle_pkg::disp_sel_t i_sel,
   output logic [7:0]           o_seg0,
   output logic [7:0]           o_seg1
);

   // low byte of the shown angle and its selection
   logic [7:0]           shown_q;
   angle_pkg::disp_sel_t sel_q;
   logic [6:0]           digit_lo;
   logic [6:0]           digit_hi;

   always_ff @(posedge i_CLK or negedge i_RST) begin
      if (!i_RST) begin
         // theta comes out of reset selected
         shown_q <= angle_pkg::THETA_INIT[7:0];
         sel_q   <= angle_pkg::DISP_THETA;
      end else begin
         shown_q <= (i_sel == angle_pkg::DISP_PHI) ? i_phi[7:0] : i_theta[7:0];
         sel_q   <= i_sel;
      end
   end

   hex2seg u_hex_lo (
      .i_num (shown_q[3:0]),
      .o_seg (digit_lo)
   );

   hex2seg u_hex_hi (
      .i_num (shown_q[7:4]),
      .o_seg (digit_hi)
   );

   // bit 7 is the point, low means lit
   assign o_seg0 = {~(sel_q == angle_pkg::DISP_PHI), digit_lo};
   assign o_seg1 = {1'b1, digit_hi};

endmodule

//--- hdl/value_control.sv
/*
 * saturating up/down step counter for one angle
 */

`timescale 1ns/10ps

module value_control #(
   parameter angle_pkg::angle_t MIN_VAL  = 9'd0,
   parameter angle_pkg::angle_t MAX_VAL  = 9'd255,
   parameter angle_pkg::angle_t STEP     = 9'd1,
   parameter angle_pkg::angle_t INIT_VAL = 9'd0
) (
   input  logic              i_CLK,
   input  logic              i_RST,
   input  logic              i_up,
   input  logic              i_down,
   output angle_pkg::angle_t o_value
);

   angle_pkg::angle_t value_nxt;

   // ------------------------------------------------------------------------
   // next value
   // ------------------------------------------------------------------------
   // compare before stepping so nothing wraps at the range ends
   always_comb begin
      value_nxt = o_value;
      if (i_down) begin
         // down wins when both arrive together
         if (o_value < MIN_VAL + STEP)
            value_nxt = MIN_VAL;
         else
            value_nxt = o_value - STEP;
      end else if (i_up) begin
         if (o_value > MAX_VAL - STEP)
            value_nxt = MAX_VAL;
         else
            value_nxt = o_value + STEP;
      end
   end

   always_ff @(posedge i_CLK or negedge i_RST) begin
      if (!i_RST) begin
         o_value <= INIT_VAL;
      end else begin
         o_value <= value_nxt;
      end
   end

   // counter never leaves its range
   a_value_range: assert property (
      @(posedge i_CLK) disable iff (!i_RST)
      (o_value >= MIN_VAL) && (o_value <= MAX_VAL)
   );

endmodule

//--- verif/angle_checker.sv
/*
 * scoreboard for the angle unit: accepted R and B beats, held responses
 * and the two display digits, with per-test summary lines
 */

`timescale 1ns/10ps

module angle_checker (
   input  logic        i_CLK,
   input  logic        i_rvalid,
   input  logic        i_rready,
   input  logic [31:0] i_rdata,
   input  logic [1:0]  i_rresp,
   input  logic        i_bvalid,
   input  logic        i_bready,
   input  logic [1:0]  i_bresp,
   input  logic [7:0]  i_seg0,
   input  logic [7:0]  i_seg1,
   // expectations from the testbench model
   input  logic [31:0] i_exp_value,
   input  logic        i_exp_crad,
   input  logic [1:0]  i_exp_resp,
   input  logic        i_seg_chk,
   input  logic [7:0]  i_seg_angle,
   input  logic        i_seg_phi,
   input  logic        i_test_end,
   input  int          i_test_id,
   output int          o_checks,
   output int          o_errors
);

   int          n_checks = 0;
   int          n_errors = 0;
   int          test_checks = 0;
   int          test_errors = 0;
   // response still pending at the last edge
   logic        r_hold = 1'b0;
   logic        b_hold = 1'b0;
   logic [31:0] r_prev;
   logic [1:0]  b_prev;
   logic [31:0] exp_rd;
   logic [15:0] exp_seg;

   assign o_checks = n_checks;
   assign o_errors = n_errors;

   // ------------------------------------------------------------------------
   // reference functions
   // ------------------------------------------------------------------------
   // degrees times 1787, then drop 10 bits
   function automatic logic [15:0] crad_of(input logic [31:0] deg);
      logic [31:0] prod;
      prod = deg * 32'd1787;
      return prod[25:10];
   endfunction

   // standard a..g pattern, a in bit 0, inverted for the board
   function automatic logic [6:0] digit_of(input logic [3:0] nib);
      logic [6:0] lit;
      case (nib)
         4'h0: lit = 7'h3F;
         4'h1: lit = 7'h06;
         4'h2: lit = 7'h5B;
         4'h3: lit = 7'h4F;
         4'h4: lit = 7'h66;
         4'h5: lit = 7'h6D;
         4'h6: lit = 7'h7D;
         4'h7: lit = 7'h07;
         4'h8: lit = 7'h7F;
         4'h9: lit = 7'h6F;
         4'hA: lit = 7'h77;
         4'hB: lit = 7'h7C;
         4'hC: lit = 7'h39;
         4'hD: lit = 7'h5E;
         4'hE: lit = 7'h79;
         default: lit = 7'h71;
      endcase
      return ~lit;
   endfunction

   // {seg1, seg0}, low digit point lit for phi
   function automatic logic [15:0] seg_of(input logic [7:0] val, input logic phi);
      return {1'b1, digit_of(val[7:4]), ~phi, digit_of(val[3:0])};
   endfunction

   task automatic compare(input string name, input logic [31:0] got,
                          input logic [31:0] exp);
      n_checks++;
      test_checks++;
      if (got !== exp) begin
         n_errors++;
         test_errors++;
         $display("** Error test %0d: %s = 0x%0h, expected 0x%0h",
                  i_test_id, name, got, exp);
      end
   endtask

   // ------------------------------------------------------------------------
   // compare at each rising edge
   // ------------------------------------------------------------------------
   always @(posedge i_CLK) begin
      // read beat taken at this edge
      if (i_rvalid && i_rready) begin
         exp_rd = i_exp_crad ? {16'h0, crad_of(i_exp_value)} : i_exp_value;
         compare("o_rdata", i_rdata, exp_rd);
         compare("o_rresp", {30'h0, i_rresp}, {30'h0, i_exp_resp});
      end
      // stalled beat must not move
      if (r_hold)
         compare("o_rdata held", i_rdata, r_prev);
      r_hold = i_rvalid && !i_rready;
      r_prev = i_rdata;

      if (i_bvalid && i_bready)
         compare("o_bresp", {30'h0, i_bresp}, {30'h0, i_exp_resp});
      if (b_hold)
         compare("o_bresp held", {30'h0, i_bresp}, {30'h0, b_prev});
      b_hold = i_bvalid && !i_bready;
      b_prev = i_bresp;

      if (i_seg_chk) begin
         exp_seg = seg_of(i_seg_angle, i_seg_phi);
         compare("o_seg1", {24'h0, i_seg1}, {24'h0, exp_seg[15:8]});
         compare("o_seg0", {24'h0, i_seg0}, {24'h0, exp_seg[7:0]});
      end

      if (i_test_end) begin
         $display("test %0d finished: %0d checks, %0d errors",
                  i_test_id, test_checks, test_errors);
         test_checks = 0;
         test_errors = 0;
      end
   end

endmodule

//--- verif/tb_angle_control.sv
/*
 * clock, reset, LCG, button and AXI4-Lite stimulus for the angle unit
 * with a reference model of theta, phi and the display select
 */

`timescale 1ns/10ps

module tb_angle_control;

   localparam int          CLK_PERIOD  = 40;
   localparam int          TIMEOUT_CYC = 64;
   localparam logic [31:0] SEED        = 32'ha8ea_dc29;
   // what wait_for is waiting on
   localparam int WAIT_AR = 0;
   localparam int WAIT_R  = 1;
   localparam int WAIT_AW = 2;
   localparam int WAIT_B  = 3;

   logic        clk;
   logic        rst_n;
   logic        btn_theta_up;
   logic        btn_theta_dn;
   logic        btn_phi_up;
   logic        btn_phi_dn;
   logic [7:0]  seg0;
   logic [7:0]  seg1;
   logic        awvalid;
   logic        awready;
   logic [4:0]  awaddr;
   logic        wvalid;
   logic        wready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        bvalid;
   logic        bready;
   logic [1:0]  bresp;
   logic        arvalid;
   logic        arready;
   logic [4:0]  araddr;
   logic        rvalid;
   logic        rready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   // expectations handed to the checker
   logic [31:0] exp_value;
   logic        exp_crad;
   logic [1:0]  exp_resp;
   logic        seg_chk;
   logic [7:0]  seg_angle;
   logic        seg_phi;
   logic        test_end;
   int          test_id;
   int          n_checks;
   int          n_errors;
   // reference model
   angle_pkg::angle_t theta_m;
   angle_pkg::angle_t phi_m;
   logic              sel_m;
   logic [31:0]       rand_state;

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   angle_control_top DUT (
      .i_CLK (clk), .i_RST (rst_n),
      .i_btn_theta_up (btn_theta_up), .i_btn_theta_dn (btn_theta_dn),
      .i_btn_phi_up (btn_phi_up), .i_btn_phi_dn (btn_phi_dn),
      .o_seg0 (seg0), .o_seg1 (seg1),
      .i_awvalid (awvalid), .o_awready (awready), .i_awaddr (awaddr),
      .i_wvalid (wvalid), .o_wready (wready), .i_wdata (wdata), .i_wstrb (wstrb),
      .o_bvalid (bvalid), .i_bready (bready), .o_bresp (bresp),
      .i_arvalid (arvalid), .o_arready (arready), .i_araddr (araddr),
      .o_rvalid (rvalid), .i_rready (rready), .o_rdata (rdata), .o_rresp (rresp)
   );

   angle_checker u_checker (
      .i_CLK (clk), .i_rvalid (rvalid), .i_rready (rready), .i_rdata (rdata),
      .i_rresp (rresp), .i_bvalid (bvalid), .i_bready (bready), .i_bresp (bresp),
      .i_seg0 (seg0), .i_seg1 (seg1), .i_exp_value (exp_value), .i_exp_crad (exp_crad),
      .i_exp_resp (exp_resp), .i_seg_chk (seg_chk), .i_seg_angle (seg_angle),
      .i_seg_phi (seg_phi), .i_test_end (test_end), .i_test_id (test_id),
      .o_checks (n_checks), .o_errors (n_errors)
   );

   // ------------------------------------------------------------------------
   // model and helpers
   // ------------------------------------------------------------------------
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // one press where down beats up and the result is clamped to the range
   function automatic angle_pkg::angle_t next_angle(
      input angle_pkg::angle_t cur, input logic up, input logic dn,
      input angle_pkg::angle_t lo, input angle_pkg::angle_t hi,
      input angle_pkg::angle_t step);
      int v;
      v = int'(cur);
      if (dn)
         v = (v - int'(step) < int'(lo)) ? int'(lo) : v - int'(step);
      else if (up)
         v = (v + int'(step) > int'(hi)) ? int'(hi) : v + int'(step);
      return angle_pkg::angle_t'(v);
   endfunction

   // inputs move 2 ns after the edge
   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic random_wait();
      rand_state = lcg_next(rand_state);
      repeat (rand_state[17:16]) next_cycle();
   endtask

   task automatic abort_timeout(input string what);
      $display("timeout: no %s within %0d cycles", what, TIMEOUT_CYC);
      $display("CHECKS FAILED");
      $finish;
   endtask

   task automatic wait_for(input int which, input string what);
      int   cnt;
      logic seen;
      cnt  = 0;
      seen = 1'b0;
      while (!seen && cnt <= TIMEOUT_CYC) begin
         case (which)
            WAIT_AR: seen = arready;
            WAIT_R:  seen = rvalid;
            // address and data ready come together
            WAIT_AW: seen = awready & wready;
            default: seen = bvalid;
         endcase
         if (!seen) begin
            cnt++;
            next_cycle();
         end
      end
      if (!seen)
         abort_timeout(what);
   endtask

   // mask is {phi_dn, phi_up, theta_dn, theta_up}
   task automatic press_button(input logic [3:0] mask);
      btn_theta_up = ~mask[0];
      btn_theta_dn = ~mask[1];
      btn_phi_up   = ~mask[2];
      btn_phi_dn   = ~mask[3];
      repeat (4) next_cycle();
      btn_theta_up = 1'b1;
      btn_theta_dn = 1'b1;
      btn_phi_up   = 1'b1;
      btn_phi_dn   = 1'b1;
      repeat (4) next_cycle();
      theta_m = next_angle(theta_m, mask[0], mask[1], angle_pkg::THETA_MIN,
                           angle_pkg::THETA_MAX, angle_pkg::THETA_STEP);
      phi_m   = next_angle(phi_m, mask[2], mask[3], angle_pkg::PHI_MIN,
                           angle_pkg::PHI_MAX, angle_pkg::PHI_STEP);
   endtask

   task automatic axil_read(input logic [4:0] addr, input logic [31:0] exp,
                            input logic crad, input logic [1:0] resp);
      exp_value = exp;
      exp_crad  = crad;
      exp_resp  = resp;
      araddr    = addr;
      arvalid   = 1'b1;
      wait_for(WAIT_AR, "read address ready");
      // handshake edge
      next_cycle();
      arvalid = 1'b0;
      wait_for(WAIT_R, "read data valid");
      random_wait();
      rready = 1'b1;
      next_cycle();
      rready = 1'b0;
   endtask

   task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input logic [1:0] resp);
      exp_resp = resp;
      awaddr   = addr;
      wdata    = data;
      wstrb    = strb;
      awvalid  = 1'b1;
      wvalid   = 1'b1;
      wait_for(WAIT_AW, "write address and data ready");
      next_cycle();
      awvalid = 1'b0;
      wvalid  = 1'b0;
      wait_for(WAIT_B, "write response valid");
      random_wait();
      bready = 1'b1;
      next_cycle();
      bready = 1'b0;
   endtask

   task automatic read_deg(input logic [4:0] addr, input angle_pkg::angle_t val);
      axil_read(addr, {23'h0, val}, 1'b0, angle_pkg::RESP_OKAY);
   endtask

   task automatic check_display();
      seg_angle = sel_m ? phi_m[7:0] : theta_m[7:0];
      seg_phi   = sel_m;
      seg_chk   = 1'b1;
      next_cycle();
      seg_chk   = 1'b0;
   endtask

   task automatic end_test();
      test_end = 1'b1;
      next_cycle();
      test_end = 1'b0;
   endtask

   // ------------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------------
   initial begin
      logic [3:0] mask;
      int         i;
      rand_state   = SEED;
      rst_n        = 1'b0;
      btn_theta_up = 1'b1;
      btn_theta_dn = 1'b1;
      btn_phi_up   = 1'b1;
      btn_phi_dn   = 1'b1;
      awvalid      = 1'b0;
      awaddr       = 5'h0;
      wvalid       = 1'b0;
      wdata        = 32'h0;
      wstrb        = 4'h0;
      bready       = 1'b0;
      arvalid      = 1'b0;
      araddr       = 5'h0;
      rready       = 1'b0;
      exp_value    = 32'h0;
      exp_crad     = 1'b0;
      exp_resp     = 2'b00;
      seg_chk      = 1'b0;
      seg_angle    = 8'h0;
      seg_phi      = 1'b0;
      test_end     = 1'b0;
      test_id      = 0;
      theta_m      = angle_pkg::THETA_INIT;
      phi_m        = angle_pkg::PHI_INIT;
      sel_m        = 1'b0;
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      next_cycle();

      // reset values
      test_id = 1;
      read_deg(angle_pkg::REG_THETA_DEG, theta_m);
      read_deg(angle_pkg::REG_PHI_DEG, phi_m);
      check_display();
      end_test();

      // theta down to 30 and back up to 180
      test_id = 2;
      for (i = 0; i < 40; i++) begin
         press_button(4'b0010);
         read_deg(angle_pkg::REG_THETA_DEG, theta_m);
      end
      for (i = 0; i < 40; i++) begin
         press_button(4'b0001);
         read_deg(angle_pkg::REG_THETA_DEG, theta_m);
      end
      check_display();
      end_test();

      // random phi walk biased upward
      test_id = 3;
      for (i = 0; i < 40; i++) begin
         rand_state = lcg_next(rand_state);
         mask = (rand_state[31:29] < 3'd5) ? 4'b0100 : 4'b1000;
         press_button(mask);
         read_deg(angle_pkg::REG_PHI_DEG, phi_m);
      end
      end_test();

      // up and down on the same edges
      test_id = 4;
      press_button(4'b0011);
      read_deg(angle_pkg::REG_THETA_DEG, theta_m);
      press_button(4'b1100);
      read_deg(angle_pkg::REG_PHI_DEG, phi_m);
      end_test();

      // centiradians and display select
      test_id = 5;
      axil_read(angle_pkg::REG_THETA_CRAD, {23'h0, theta_m}, 1'b1, angle_pkg::RESP_OKAY);
      axil_read(angle_pkg::REG_PHI_CRAD, {23'h0, phi_m}, 1'b1, angle_pkg::RESP_OKAY);
      axil_write(angle_pkg::REG_CTRL, 32'h1, 4'hF, angle_pkg::RESP_OKAY);
      sel_m = 1'b1;
      check_display();
      // strobe 0 low keeps the select on phi
      axil_write(angle_pkg::REG_CTRL, 32'h0, 4'hE, angle_pkg::RESP_OKAY);
      axil_read(angle_pkg::REG_CTRL, {31'h0, sel_m}, 1'b0, angle_pkg::RESP_OKAY);
      press_button(4'b0100);
      check_display();
      axil_read(angle_pkg::REG_PHI_CRAD, {23'h0, phi_m}, 1'b1, angle_pkg::RESP_OKAY);
      end_test();

      // error responses
      test_id = 6;
      axil_write(angle_pkg::REG_THETA_DEG, 32'h55, 4'hF, angle_pkg::RESP_SLVERR);
      axil_write(angle_pkg::REG_PHI_CRAD, 32'h12, 4'hF, angle_pkg::RESP_SLVERR);
      axil_write(5'h14, 32'h1, 4'hF, angle_pkg::RESP_SLVERR);
      axil_read(5'h14, 32'h0, 1'b0, angle_pkg::RESP_SLVERR);
      axil_read(5'h1C, 32'h0, 1'b0, angle_pkg::RESP_SLVERR);
      read_deg(angle_pkg::REG_THETA_DEG, theta_m);
      end_test();

      next_cycle();
      $display("total: %0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0 && n_checks > 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

//--- verilog.f
hdl/angle_pkg.sv
hdl/button_edge.sv
hdl/value_control.sv
hdl/hex2seg.sv
hdl/seg_display.sv
hdl/angle_regs_axil.sv
hdl/angle_control_top.sv
verif/angle_checker.sv
verif/tb_angle_control.sv
